// File: tt_um_dlmiles_muldiv4.f
hw/muldiv_pkg.sv
hw/tt_pins_pkg.sv
hw/p22_mul4.sv
hw/p22_div4.sv
hw/tt_um_dlmiles_muldiv4.sv
tests/tb_clock_gen.sv
tests/tb_muldiv4.sv

// File: Makefile
# Verilator build and run of the muldiv4 testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_muldiv4
FILELIST  := tt_um_dlmiles_muldiv4.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, the simulator exit code alone is not enough
test: $(SIM_BIN)
	rm -f $(LOG)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
	rm -f $(LOG)

// File: tests/tb_muldiv4.sv
`timescale 1ns/1ps

module tb_muldiv4;

    localparam int RESET_CYCLES  = 10;
    localparam int SWEEP_VECTORS = 256;    // every operand pair
    localparam int SWEEPS        = 4;
    localparam int HOLD_VECTORS  = 200;
    localparam int FLUSH_CYCLES  = 4;      // per test, pipeline drain plus slack
    localparam int TEST_COUNT    = 6;
    localparam int PERIOD_NS     = 100;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + SWEEPS * SWEEP_VECTORS + HOLD_VECTORS
                                   + TEST_COUNT * FLUSH_CYCLES;
    localparam int WATCHDOG_NS   = 2 * TOTAL_CYCLES * PERIOD_NS;

    // pins as seen one edge after the inputs
    typedef struct packed {
        logic [7:0] uo;
        logic [7:0] uio;
    } pins_out_t;

    logic       clk;
    logic       rst_n;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic       ena;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    pins_out_t  exp_out = '0;        // model of the output register
    logic       model_valid = 1'b0;  // first edge seen, dut outputs defined from here
    integer     seed = 32'h326715c2;
    int         err_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tt_um_dlmiles_muldiv4 dut (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    // nibble as two's complement
    function automatic int as_signed(input logic [3:0] n);
        return n[3] ? int'(n) - 16 : int'(n);
    endfunction

    // reference for one vector, straight from the arithmetic rules
    function automatic pins_out_t expect_outputs(input logic [7:0] ui, input logic [7:0] uio);
        logic [3:0] a;
        logic [3:0] b;
        int         av;
        int         bv;
        int         prod;
        int         q;
        int         r;
        pins_out_t  res;
        a   = ui[3:0];
        b   = ui[7:4];
        av  = uio[6] ? as_signed(a) : int'(a);
        bv  = uio[6] ? as_signed(b) : int'(b);
        res = '0;
        if (!uio[7]) begin
            prod   = av * bv;
            res.uo = prod[7:0];              // 8-bit wrap covers both modes
        end else if (b == 4'h0) begin
            res.uo     = {a, 4'hf};          // remainder = dividend, quotient all ones
            res.uio[5] = 1'b1;
        end else if (uio[6] && av == -8 && bv == -1) begin
            res.uo     = 8'h08;
            res.uio[4] = 1'b1;
        end else begin
            q      = av / bv;                // int division truncates toward zero
            r      = av % bv;                // sign follows the dividend
            res.uo = {r[3:0], q[3:0]};
        end
        return res;
    endfunction

    always @(posedge clk) begin
        model_valid <= 1'b1;
        if (!rst_n) begin
            exp_out <= '0;
        end else if (ena) begin
            exp_out <= expect_outputs(ui_in, uio_in);
        end
    end

    uo_match: assert property (@(posedge clk) model_valid |-> uo_out == exp_out.uo)
        else begin
            err_count++;
            $display("FAILED uo_out expected %02h got %02h at %0t",
                     $sampled(exp_out.uo), $sampled(uo_out), $time);
        end

    uio_match: assert property (@(posedge clk) model_valid |-> uio_out == exp_out.uio)
        else begin
            err_count++;
            $display("FAILED uio_out expected %02h got %02h at %0t",
                     $sampled(exp_out.uio), $sampled(uio_out), $time);
        end

    // bits 4 and 5 drive, the rest stay inputs
    oe_fixed: assert property (@(posedge clk) uio_oe == 8'b0011_0000)
        else begin
            err_count++;
            $display("FAILED uio_oe expected 30 got %02h at %0t", $sampled(uio_oe), $time);
        end

    reset_clears: assert property (@(posedge clk) !rst_n |=> uo_out == 8'h00 && uio_out == 8'h00)
        else begin
            err_count++;
            $display("FAILED uo_out/uio_out after reset expected 00/00 got %02h/%02h",
                     $sampled(uo_out), $sampled(uio_out));
        end

    ena_holds: assert property (@(posedge clk) rst_n && !ena |=> $stable(uo_out) && $stable(uio_out))
        else begin
            err_count++;
            $display("outputs changed after a cycle with ena low at %0t", $time);
        end

    // one vector per falling edge
    task automatic drive_vector(input logic [7:0] operands, input logic is_div,
                                input logic is_signed, input logic enable,
                                input logic [5:0] spare);
        @(negedge clk);
        ui_in  = operands;                   // b high nibble, a low nibble
        uio_in = {is_div, is_signed, spare};
        ena    = enable;
    endtask

    // last vector is checked two rising edges later
    task automatic flush_pipeline();
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before, input int vectors);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: passed, %0d vectors", name, vectors);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches over %0d vectors",
                     name, err_count - errs_before, vectors);
        end
    endtask

    // inputs keep moving during reset, outputs must not follow
    task automatic run_reset_test();
        int         errs_before;
        logic [31:0] rnd;
        errs_before = err_count;
        repeat (RESET_CYCLES) begin
            rnd = $random(seed);
            drive_vector(rnd[7:0], rnd[8], rnd[9], 1'b1, rnd[15:10]);
        end
        wait (rst_n === 1'b1);
        flush_pipeline();
        report_test("reset and fixed pins", errs_before, RESET_CYCLES);
    endtask

    task automatic run_sweep(input string name, input logic is_div, input logic is_signed);
        int errs_before;
        errs_before = err_count;
        for (int i = 0; i < SWEEP_VECTORS; i++) begin
            drive_vector(i[7:0], is_div, is_signed, 1'b1, 6'h00);
        end
        flush_pipeline();
        report_test(name, errs_before, SWEEP_VECTORS);
    endtask

    // random modes, ena low about one cycle in four
    task automatic run_hold_test();
        int          errs_before;
        logic [31:0] rnd;
        errs_before = err_count;
        for (int i = 0; i < HOLD_VECTORS; i++) begin
            rnd = $random(seed);
            drive_vector(rnd[7:0], rnd[8], rnd[9], rnd[17:16] != 2'b00, rnd[15:10]);
        end
        flush_pipeline();
        report_test("enable hold", errs_before, HOLD_VECTORS);
    endtask

    initial begin
        ui_in  = 8'h00;
        uio_in = 8'h00;
        ena    = 1'b0;
        run_reset_test();
        run_sweep("unsigned multiply", 1'b0, 1'b0);
        run_sweep("signed multiply", 1'b0, 1'b1);
        run_sweep("unsigned divide", 1'b1, 1'b0);
        run_sweep("signed divide", 1'b1, 1'b1);
        run_hold_test();
        $display("tests passed %0d, failed %0d, mismatches %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // twice the expected run length
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

// free running clock plus a power-on reset
module tb_clock_gen (
    output logic clk,
    output logic rst_n      // sync, active low
);

    localparam int HALF_PERIOD_NS = 50;     // 100 ns period
    localparam int RESET_CYCLES   = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: hw/tt_um_dlmiles_muldiv4.sv
`timescale 1ns/1ps
`default_nettype none

// tiny tapeout wrapper around the 4-bit multiplier and divider
// ui_in carries both operands
// uio_in[7:6] pick the operation
// one output register stage loaded while ena is high
module tt_um_dlmiles_muldiv4 (
    input  logic [7:0] ui_in,      // b in [7:4] and a in [3:0]
    output logic [7:0] uo_out,     // product or {remainder, quotient}
    input  logic [7:0] uio_in,     // bits 6,7 are controls
    output logic [7:0] uio_out,    // bits 4,5 are error flags
    output logic [7:0] uio_oe,     // fixed direction
    input  logic       ena,        // high while the design is selected
    input  logic       clk,
    input  logic       rst_n       // synchronous active low
);

    import muldiv_pkg::*;
    import tt_pins_pkg::*;

    pin_ctrl_t   ctrl;
    operand_t    op_a;             // multiplicand / dividend
    operand_t    op_b;             // multiplier / divisor
    product_t    mul_p;
    div_result_t div_res;

    logic [7:0]  uo_next;          // value to register on the next edge
    logic [7:0]  uio_next;

    // pin decode
    assign ctrl.muldiv   = uio_in[UI7_MULDIV_BITID];
    assign ctrl.opsigned = uio_in[UI6_US_BITID];

    assign op_a = ui_in[OPERAND_WIDTH-1:0];
    assign op_b = ui_in[PRODUCT_WIDTH-1:OPERAND_WIDTH];

    // only 4 and 5 ever drive
    assign uio_oe = UIO_OE_PATTERN;

    p22_mul4 mul4 (
        .opsigned (ctrl.opsigned),
        .a        (op_a),
        .b        (op_b),
        .p        (mul_p)
    );

    p22_div4 div4 (
        .opsigned (ctrl.opsigned),
        .dividend (op_a),
        .divisor  (op_b),
        .result   (div_res)
    );

    // both units always run and the mode picks one
    always_comb begin
        if (ctrl.muldiv) begin
            uo_next = {div_res.remainder, div_res.quotient};    // remainder high, quotient low
        end else begin
            uo_next = mul_p;
        end

        uio_next = '0;                  // unused and input bits read back as 0
        // flags only mean something in divide mode
        uio_next[UO4_EOVER_BITID] = ctrl.muldiv & div_res.eover;
        uio_next[UO5_EDIV0_BITID] = ctrl.muldiv & div_res.ediv0;
    end

    // output stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uo_out  <= '0;
            uio_out <= '0;              // flags inactive out of reset
        end else if (ena) begin
            uo_out  <= uo_next;
            uio_out <= uio_next;
        end
        // ena low holds the last result
    end

    // a non-zero bit outside the enabled pair would fight the pad inputs
    assert property (@(posedge clk) (uio_out & ~UIO_OE_PATTERN) == 8'h00)
        else $error("uio_out drives bits outside the output pair: %02h", uio_out);

endmodule

// File: hw/p22_div4.sv
`timescale 1ns/1ps
`default_nettype none

// 4/4 combinational divider
// restoring division on magnitudes, signs patched up afterwards
// quotient truncates toward zero, remainder follows the dividend
module p22_div4 (
    input  logic                   opsigned,   // 1 = two's complement operands
    input  muldiv_pkg::operand_t   dividend,
    input  muldiv_pkg::operand_t   divisor,
    output muldiv_pkg::div_result_t result
);

    import muldiv_pkg::*;

    // sign handling
    logic     dvd_neg;          // dividend negative, also the remainder sign
    logic     dvs_neg;          // divisor negative
    logic     quo_neg;          // signs differ
    operand_t dvd_mag;          // |dividend|, -8 stays 4'b1000 which is 8 unsigned
    operand_t dvs_mag;          // |divisor|

    // unsigned core
    operand_t                 q_mag;       // magnitude quotient
    logic [OPERAND_WIDTH:0]   r_mag;       // partial remainder, one spare bit
    logic [OPERAND_WIDTH+1:0] trial;       // r_mag minus divisor, borrow on top

    // errors
    logic div0;
    logic over;

    always_comb begin
        dvd_neg = opsigned & dividend[OPERAND_WIDTH-1];
        dvs_neg = opsigned & divisor[OPERAND_WIDTH-1];
        quo_neg = dvd_neg ^ dvs_neg;
        dvd_mag = dvd_neg ? operand_t'(-dividend) : dividend;
        dvs_mag = dvs_neg ? operand_t'(-divisor)  : divisor;
    end

    // four unrolled restoring steps, msb first
    always_comb begin
        r_mag = '0;
        q_mag = '0;
        trial = '0;
        for (int i = OPERAND_WIDTH - 1; i >= 0; i--) begin
            r_mag = {r_mag[OPERAND_WIDTH-1:0], dvd_mag[i]};    // bring down next bit
            trial = {1'b0, r_mag} - {2'b00, dvs_mag};
            if (!trial[OPERAND_WIDTH+1]) begin                // no borrow, keep it
                r_mag    = trial[OPERAND_WIDTH:0];
                q_mag[i] = 1'b1;
            end else begin
                q_mag[i] = 1'b0;                              // restore, r_mag untouched
            end
        end
    end

    // zero divisor wins in either mode
    // overflow is the single signed case -8 / -1
    always_comb begin
        div0 = (divisor == '0);
        over = opsigned && (dividend == operand_t'(4'b1000))
                        && (divisor == operand_t'(4'b1111));
    end

    always_comb begin
        operand_t chk;      // q * d + r, wrapped to a nibble

        result.ediv0 = div0;
        result.eover = over;

        if (div0) begin
            result.quotient  = '1;             // all ones
            result.remainder = dividend;       // dividend passes through
        end else if (over) begin
            result.quotient  = operand_t'(4'b1000);   // +8 does not fit, wraps to -8
            result.remainder = '0;
        end else begin
            result.quotient  = quo_neg ? operand_t'(-q_mag) : q_mag;
            result.remainder = dvd_neg ? operand_t'(-r_mag[OPERAND_WIDTH-1:0])
                                       : r_mag[OPERAND_WIDTH-1:0];
        end

        chk = operand_t'(result.quotient * divisor + result.remainder);

        // the two error paths come from different divisor values
        assert (!(result.ediv0 && result.eover))
            else $error("div4: ediv0 and eover both set");

        // mod 16 the identity also covers signed results
        if (!result.ediv0 && !result.eover) begin
            assert (chk == dividend)
                else $error("div4: %0h * %0h + %0h != %0h",
                            result.quotient, divisor, result.remainder, dividend);
        end
    end

endmodule

// File: hw/p22_mul4.sv
`timescale 1ns/1ps
`default_nettype none

// 4x4 combinational multiplier
// unsigned, or two's complement when opsigned is set
module p22_mul4 (
    input  logic               opsigned,   // 1 = two's complement operands
    input  muldiv_pkg::operand_t a,
    input  muldiv_pkg::operand_t b,
    output muldiv_pkg::product_t p
);

    import muldiv_pkg::*;

    product_t a_ext;                   // multiplicand widened to product size
    product_t pp [OPERAND_WIDTH];      // one partial product per bit of b
    product_t pp_low_sum;              // sum of the positive-weight rows

    // widen a, sign or zero fill
    always_comb begin
        if (opsigned) begin
            a_ext = {{(PRODUCT_WIDTH-OPERAND_WIDTH){a[OPERAND_WIDTH-1]}}, a};
        end else begin
            a_ext = {{(PRODUCT_WIDTH-OPERAND_WIDTH){1'b0}}, a};
        end
    end

    // b is never widened, its msb weight is handled below
    // shift-and-add rows, row i is a_ext weighted by 2^i
    always_comb begin
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            pp[i] = b[i] ? product_t'(a_ext << i) : '0;
        end
    end

    // rows 0..2 always carry positive weight
    always_comb begin
        pp_low_sum = '0;
        for (int i = 0; i < OPERAND_WIDTH - 1; i++) begin
            pp_low_sum = pp_low_sum + pp[i];
        end
    end

    // top row has weight -8 when b is signed
    // subtracting it is the usual Baugh-Wooley correction, all mod 256
    always_comb begin
        if (opsigned) begin
            p = pp_low_sum - pp[OPERAND_WIDTH-1];
        end else begin
            p = pp_low_sum + pp[OPERAND_WIDTH-1];
        end

        // 15 * 15 is the largest unsigned product
        // catches a bad row weight or a stray sign fill
        if (!opsigned) begin
            assert (p <= product_t'(225))
                else $error("mul4: unsigned product %0d out of range", p);
        end
    end

endmodule

// File: hw/tt_pins_pkg.sv
package tt_pins_pkg;

    // uio_out flag positions
    localparam int UO4_EOVER_BITID = 4;     // overflow
    localparam int UO5_EDIV0_BITID = 5;     // divide by zero

    // uio_in control positions
    localparam int UI6_US_BITID     = 6;    // 0 unsigned, 1 signed
    localparam int UI7_MULDIV_BITID = 7;    // 0 multiply, 1 divide

    // bidir direction never changes
    // bits 4,5 drive the error flags, everything else stays an input
    localparam logic [7:0] UIO_OE_PATTERN = 8'b0011_0000;

    // control decoded from uio_in
    typedef struct packed {
        logic muldiv;       // divide select
        logic opsigned;     // signed select
    } pin_ctrl_t;

endpackage

// File: hw/muldiv_pkg.sv
package muldiv_pkg;

    // operand width, fixed by the pin map (two nibbles on ui_in)
    localparam int OPERAND_WIDTH = 4;

    // full product, no truncation
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // one nibble: operand, quotient or remainder
    typedef logic [OPERAND_WIDTH-1:0] operand_t;

    // 8-bit product, unsigned or two's complement
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // divider output bundle
    // remainder sits on top so {remainder, quotient} maps straight onto uo_out
    typedef struct packed {
        operand_t remainder;    // sign follows the dividend
        operand_t quotient;     // truncated toward zero
        logic     ediv0;        // divisor was zero
        logic     eover;        // signed -8 / -1
    } div_result_t;

endpackage
